/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := riscv_v_csr_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
rtl/riscv_pkg.sv
rtl/riscv_v_pkg.sv
rtl/riscv_v_vsetvl.sv
rtl/riscv_v_csr.sv
rtl/riscv_v_csr_access.sv
rtl/riscv_v_csr_top.sv
dv/tb_clk_gen.sv
dv/riscv_v_csr_tb.sv

/* dv/riscv_v_csr_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the vector CSR block
// Drives Zicsr and vsetvl requests and checks each
// response against a register model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module riscv_v_csr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import riscv_pkg::*;

    localparam int VLEN        = 128;
    localparam int HANG_CYCLES = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    csr_op_t     req_op;
    logic [11:0] req_addr;
    logic [31:0] req_wdata;
    logic [31:0] req_avl;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    logic        rsp_err;
    logic        sat_set;

    int          seed;
    int          n_issued;
    int          cycle_count;

    // Register model and the expected response
    logic [31:0] m_vstart;
    logic        m_vxsat;
    logic [1:0]  m_vxrm;
    logic [31:0] m_vl;
    logic [31:0] m_vtype;
    logic [31:0] exp_rdata;
    logic        exp_err;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    riscv_v_csr_top #(
        .VLEN (VLEN)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_avl   (req_avl),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .sat_set   (sat_set)
    );

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "response check failed");
    endtask

    // Expected response and next state for one accepted request
    task automatic model_accept(input csr_op_t op, input logic [11:0] addr,
                                input logic [31:0] wdata, input logic [31:0] avl);
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic [31:0] vlmax;
        logic        known;
        logic        ro;
        logic        writes;
        if (op == OP_VSETVL) begin
            if (wdata[5:3] < 3'd4 && wdata[2:0] == 3'd0 && wdata[30:8] == '0) begin
                vlmax   = 32'(VLEN / (8 << wdata[5:3]));
                m_vl    = (avl < vlmax) ? avl : vlmax;
                m_vtype = {24'h0, wdata[7:0]};
            end else begin
                m_vl    = '0;
                m_vtype = 32'h8000_0000;
            end
            m_vstart  = '0;
            exp_rdata = m_vl;
            exp_err   = 1'b0;
        end else begin
            known = 1'b1;
            ro    = 1'b0;
            case (addr)
                CSR_VSTART: old_val = m_vstart;
                CSR_VXSAT:  old_val = {31'h0, m_vxsat};
                CSR_VXRM:   old_val = {30'h0, m_vxrm};
                CSR_VCSR:   old_val = {29'h0, m_vxrm, m_vxsat};
                CSR_VL: begin
                    old_val = m_vl;
                    ro      = 1'b1;
                end
                CSR_VTYPE: begin
                    old_val = m_vtype;
                    ro      = 1'b1;
                end
                CSR_VLENB: begin
                    old_val = 32'(VLEN / 8);
                    ro      = 1'b1;
                end
                default: begin
                    old_val = '0;
                    known   = 1'b0;
                end
            endcase
            // A set or clear with an empty mask only reads
            writes    = (op == OP_CSRRW) || (wdata != '0);
            exp_err   = !known || (writes && ro);
            exp_rdata = exp_err ? '0 : old_val;
            case (op)
                OP_CSRRW: new_val = wdata;
                OP_CSRRS: new_val = old_val | wdata;
                default:  new_val = old_val & ~wdata;
            endcase
            if (!exp_err && writes) begin
                case (addr)
                    CSR_VSTART: m_vstart = new_val;
                    CSR_VXSAT:  m_vxsat = new_val[0];
                    CSR_VXRM:   m_vxrm = new_val[1:0];
                    CSR_VCSR: begin
                        m_vxrm  = new_val[2:1];
                        m_vxsat = new_val[0];
                    end
                    default: ;
                endcase
            end
        end
    endtask

    // One request and its response under random back-pressure
    task automatic issue_request(input csr_op_t op, input logic [11:0] addr,
                                 input logic [31:0] wdata, input logic [31:0] avl);
        logic [31:0] rnd;
        logic        done;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_avl   = avl;
        n_issued++;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        model_accept(op, addr, wdata, avl);
        #1;
        // req_valid stays high so a second accept would show up here
        do begin
            rnd       = next_rand();
            rsp_ready = (rnd[1:0] == 2'd0);
            done      = rsp_valid && rsp_ready;
            @(posedge clk);
            #1;
        end while (!done);
        req_valid = 1'b0;
        rsp_ready = 1'b0;
    endtask

    task automatic read_csr(input logic [11:0] addr);
        issue_request(OP_CSRRS, addr, '0, '0);
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        issue_request(OP_CSRRW, addr, data, '0);
    endtask

    task automatic read_all();
        read_csr(CSR_VSTART);
        read_csr(CSR_VXSAT);
        read_csr(CSR_VXRM);
        read_csr(CSR_VCSR);
        read_csr(CSR_VL);
        read_csr(CSR_VTYPE);
        read_csr(CSR_VLENB);
    endtask

    task automatic pulse_saturation();
        sat_set = 1'b1;
        @(posedge clk);
        m_vxsat = 1'b1;
        #1;
        sat_set = 1'b0;
    endtask

    task automatic exercise_zicsr(input int count);
        logic [31:0] sel;
        logic [31:0] data;
        csr_op_t     op;
        logic [11:0] addr;
        for (int i = 0; i < count; i++) begin
            sel  = next_rand();
            data = next_rand();
            case (sel[1:0])
                2'd0:    op = OP_CSRRW;
                2'd1:    op = OP_CSRRS;
                default: op = OP_CSRRC;
            endcase
            case (sel[3:2])
                2'd0:    addr = CSR_VSTART;
                2'd1:    addr = CSR_VXSAT;
                default: addr = CSR_VXRM;
            endcase
            if (sel[5:4] == 2'd0) begin
                data = '0;
            end
            issue_request(op, addr, data, '0);
            read_csr(addr);
        end
    endtask

    task automatic sweep_vsetvl();
        logic [31:0] avl_list [8] = '{32'd0, 32'd1, 32'd3, 32'd4,
                                      32'd8, 32'd16, 32'd17, 32'hFFFF_FFFF};
        logic [31:0] sel;
        for (int s = 0; s < 8; s++) begin
            for (int a = 0; a < 8; a++) begin
                sel = next_rand();
                write_csr(CSR_VSTART, 32'd5);
                issue_request(OP_VSETVL, 12'h000, {24'h0, sel[1:0], s[2:0], 3'd0},
                              avl_list[a]);
                read_csr(CSR_VL);
                read_csr(CSR_VTYPE);
                read_csr(CSR_VSTART);
            end
        end
        for (int lm = 1; lm < 8; lm++) begin
            issue_request(OP_VSETVL, 12'h000, {26'h0, 3'd2, lm[2:0]}, 32'd10);
            read_csr(CSR_VL);
            read_csr(CSR_VTYPE);
        end
        // Reserved bit 8 set
        issue_request(OP_VSETVL, 12'h000, 32'h0000_0110, 32'd10);
        read_csr(CSR_VTYPE);
    endtask

    rsp_matches_model: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_rdata == exp_rdata && rsp_err == exp_err
    ) else report_mismatch($sformatf("rdata 0x%0h err %0b, expected 0x%0h err %0b",
                                     rsp_rdata, rsp_err, exp_rdata, exp_err));

    rsp_held: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)
    ) else report_mismatch("response changed while rsp_ready was low");

    ready_tracks_rsp: assert property (@(posedge clk) disable iff (rst)
        req_ready == !rsp_valid
    ) else report_mismatch("req_ready high while a response is pending");

    single_accept: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> !req_ready
    ) else report_mismatch("second request accepted");

    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !rsp_valid && req_ready
    ) else report_mismatch("block not idle after reset");

    initial begin
        cycle_count = 0;
        while (cycle_count <= HANG_CYCLES * (n_issued + 1)) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: no response within %0d cycles per request", HANG_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed      = 83423;
        n_issued  = 0;
        req_valid = 1'b0;
        req_op    = OP_CSRRW;
        req_addr  = '0;
        req_wdata = '0;
        req_avl   = '0;
        rsp_ready = 1'b0;
        sat_set   = 1'b0;
        m_vstart  = '0;
        m_vxsat   = 1'b0;
        m_vxrm    = 2'd0;
        m_vl      = '0;
        m_vtype   = 32'h8000_0000;
        exp_rdata = '0;
        exp_err   = 1'b0;
        @(negedge rst);
        @(posedge clk);
        #1;

        read_all();
        exercise_zicsr(40);

        write_csr(CSR_VCSR, 32'h0000_0005);
        read_csr(CSR_VXRM);
        read_csr(CSR_VXSAT);
        write_csr(CSR_VXRM, 32'd1);
        write_csr(CSR_VXSAT, 32'd0);
        read_csr(CSR_VCSR);
        issue_request(OP_CSRRS, CSR_VCSR, 32'h0000_00FF, '0);
        issue_request(OP_CSRRC, CSR_VCSR, 32'h0000_0002, '0);
        read_csr(CSR_VCSR);

        sweep_vsetvl();

        // Nontrivial state before the error cases
        write_csr(CSR_VXRM, 32'd3);
        issue_request(OP_VSETVL, 12'h000, 32'h0000_0088, 32'd6);
        write_csr(CSR_VSTART, 32'd9);
        write_csr(CSR_VL, 32'd3);
        write_csr(CSR_VTYPE, 32'd0);
        write_csr(CSR_VLENB, 32'd64);
        issue_request(OP_CSRRS, CSR_VL, 32'd1, '0);
        issue_request(OP_CSRRC, CSR_VTYPE, 32'h8000_0000, '0);
        write_csr(12'h000, 32'd1);
        write_csr(12'h00B, 32'd1);
        write_csr(12'hC23, 32'd1);
        read_csr(12'hFFF);
        read_all();

        write_csr(CSR_VXSAT, 32'd0);
        pulse_saturation();
        read_csr(CSR_VXSAT);
        read_csr(CSR_VXSAT);
        read_csr(CSR_VCSR);
        issue_request(OP_CSRRC, CSR_VXSAT, 32'd1, '0);
        read_csr(CSR_VXSAT);

        $display("test passed");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 10 ns clock, reset held for 8 rising edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* rtl/riscv_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scalar-side definitions for the vector CSR block
// Data width, request opcodes and CSR addresses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package riscv_pkg;

    localparam int XLEN = 32;

    // Request operation from the scalar core
    typedef enum logic [1:0] {
        OP_CSRRW  = 2'd0,
        OP_CSRRS  = 2'd1,
        OP_CSRRC  = 2'd2,
        OP_VSETVL = 2'd3
    } csr_op_t;

    // Vector CSR addresses
    localparam logic [11:0] CSR_VSTART = 12'h008;
    localparam logic [11:0] CSR_VXSAT  = 12'h009;
    localparam logic [11:0] CSR_VXRM   = 12'h00A;
    localparam logic [11:0] CSR_VCSR   = 12'h00F;
    localparam logic [11:0] CSR_VL     = 12'hC20;
    localparam logic [11:0] CSR_VTYPE  = 12'hC21;
    localparam logic [11:0] CSR_VLENB  = 12'hC22;

endpackage

/* rtl/riscv_v_csr.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector CSR register file
// Holds vstart, vxsat, vxrm, vl and vtype, and
// derives vlenb and vcsr
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module riscv_v_csr #(
    parameter int unsigned VLEN = 128
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sat_set,
    input  logic                         vstart_wr_en,
    input  riscv_v_pkg::riscv_v_vstart_t vstart_wdata,
    input  logic                         vxsat_wr_en,
    input  riscv_v_pkg::riscv_v_vxsat_t  vxsat_wdata,
    input  logic                         vxrm_wr_en,
    input  riscv_v_pkg::riscv_v_vxrm_t   vxrm_wdata,
    input  logic                         vl_wr_en,
    input  riscv_v_pkg::riscv_v_vl_t     vl_wdata,
    input  logic                         vtype_wr_en,
    input  riscv_v_pkg::riscv_v_vtype_t  vtype_wdata,
    output riscv_v_pkg::riscv_v_vstart_t vstart_q,
    output riscv_v_pkg::riscv_v_vxsat_t  vxsat_q,
    output riscv_v_pkg::riscv_v_vxrm_t   vxrm_q,
    output riscv_v_pkg::riscv_v_vl_t     vl_q,
    output riscv_v_pkg::riscv_v_vtype_t  vtype_q,
    output riscv_v_pkg::riscv_v_vlenb_t  vlenb_q,
    output riscv_v_pkg::riscv_v_vcsr_t   vcsr_q
);
    import riscv_v_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vstart_q <= RISCV_V_VSTART_RST_VAL;
        end else if (vstart_wr_en) begin
            vstart_q <= vstart_wdata;
        end
    end

    // Saturation from the datapath is sticky and wins over a clearing write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vxsat_q <= RISCV_V_VXSAT_RST_VAL;
        end else if (vxsat_wr_en) begin
            vxsat_q.saturate <= vxsat_wdata.saturate | sat_set;
        end else if (sat_set) begin
            vxsat_q.saturate <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vxrm_q <= RISCV_V_VXRM_RST_VAL;
        end else if (vxrm_wr_en) begin
            vxrm_q <= vxrm_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vl_q <= RISCV_V_VL_RST_VAL;
        end else if (vl_wr_en) begin
            vl_q <= vl_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vtype_q <= RISCV_V_VTYPE_RST_VAL;
        end else if (vtype_wr_en) begin
            vtype_q <= vtype_wdata;
        end
    end

    // Register length in bytes
    assign vlenb_q = riscv_v_vlenb_t'(VLEN / 8);

    assign vcsr_q.rounding_mode = vxrm_q.rounding_mode;
    assign vcsr_q.saturate      = vxsat_q.saturate;

    // Only vsetvl writes vl, so this checks the vlmax path end to end
    vl_in_range: assert property (@(posedge clk) disable iff (rst)
        vl_q <= riscv_v_vl_t'(VLEN / 8)
    ) else $error("vl 0x%0h exceeds VLEN/8", vl_q);

    regs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({vstart_q, vxsat_q, vxrm_q, vl_q, vtype_q, vlenb_q, vcsr_q})
    ) else $error("vector CSR output is unknown");

endmodule

/* rtl/riscv_v_csr_access.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector CSR access unit
// Decodes Zicsr and vsetvl requests, drives the
// register writes and holds the response
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module riscv_v_csr_access (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  riscv_pkg::csr_op_t           req_op,
    input  logic [11:0]                  req_addr,
    input  logic [riscv_pkg::XLEN-1:0]   req_wdata,
    input  logic [riscv_pkg::XLEN-1:0]   req_avl,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [riscv_pkg::XLEN-1:0]   rsp_rdata,
    output logic                         rsp_err,
    input  riscv_v_pkg::riscv_v_vstart_t vstart_q,
    input  riscv_v_pkg::riscv_v_vxsat_t  vxsat_q,
    input  riscv_v_pkg::riscv_v_vxrm_t   vxrm_q,
    input  riscv_v_pkg::riscv_v_vl_t     vl_q,
    input  riscv_v_pkg::riscv_v_vtype_t  vtype_q,
    input  riscv_v_pkg::riscv_v_vlenb_t  vlenb_q,
    input  riscv_v_pkg::riscv_v_vcsr_t   vcsr_q,
    output logic                         vstart_wr_en,
    output riscv_v_pkg::riscv_v_vstart_t vstart_wdata,
    output logic                         vxsat_wr_en,
    output riscv_v_pkg::riscv_v_vxsat_t  vxsat_wdata,
    output logic                         vxrm_wr_en,
    output riscv_v_pkg::riscv_v_vxrm_t   vxrm_wdata,
    output logic                         vl_wr_en,
    output riscv_v_pkg::riscv_v_vl_t     vl_wdata,
    output logic                         vtype_wr_en,
    output riscv_v_pkg::riscv_v_vtype_t  vtype_wdata,
    output riscv_v_pkg::riscv_v_vl_t     vset_avl,
    output riscv_v_pkg::riscv_v_vtype_t  vset_vtype,
    input  riscv_v_pkg::riscv_v_vl_t     vset_vl,
    input  riscv_v_pkg::riscv_v_vtype_t  vset_vtype_new
);
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    logic            accept;
    logic            is_vset;
    logic            is_write;
    logic            addr_ok;
    logic            read_only;
    logic            err;
    logic            csr_we;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] wr_val;

    // One request in flight
    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;

    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (req_addr)
            CSR_VSTART: old_val = vstart_q;
            CSR_VXSAT:  old_val = XLEN'(vxsat_q);
            CSR_VXRM:   old_val = XLEN'(vxrm_q);
            CSR_VCSR:   old_val = XLEN'(vcsr_q);
            CSR_VL: begin
                old_val   = vl_q;
                read_only = 1'b1;
            end
            CSR_VTYPE: begin
                old_val   = vtype_q;
                read_only = 1'b1;
            end
            CSR_VLENB: begin
                old_val   = vlenb_q;
                read_only = 1'b1;
            end
            default: begin
                old_val = '0;
                addr_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (req_op)
            OP_CSRRW: wr_val = req_wdata;
            OP_CSRRS: wr_val = old_val | req_wdata;
            OP_CSRRC: wr_val = old_val & ~req_wdata;
            default:  wr_val = old_val;
        endcase
    end

    // Set or clear with a zero mask is a plain read
    assign is_vset  = (req_op == OP_VSETVL);
    assign is_write = (req_op == OP_CSRRW) || (req_wdata != '0);
    assign err      = !is_vset && (!addr_ok || (is_write && read_only));
    assign csr_we   = accept && !is_vset && !err && is_write;

    assign vset_avl   = req_avl;
    assign vset_vtype = riscv_v_vtype_t'(req_wdata);

    assign vstart_wr_en = (accept && is_vset) || (csr_we && req_addr == CSR_VSTART);
    assign vstart_wdata = is_vset ? '0 : wr_val;

    // vcsr packs vxrm over vxsat
    assign vxsat_wr_en = csr_we && (req_addr == CSR_VXSAT || req_addr == CSR_VCSR);
    assign vxsat_wdata.saturate = wr_val[0];
    assign vxrm_wr_en  = csr_we && (req_addr == CSR_VXRM || req_addr == CSR_VCSR);
    assign vxrm_wdata.rounding_mode = (req_addr == CSR_VCSR) ? wr_val[2:1] : wr_val[1:0];

    assign vl_wr_en    = accept && is_vset;
    assign vl_wdata    = vset_vl;
    assign vtype_wr_en = accept && is_vset;
    assign vtype_wdata = vset_vtype_new;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_rdata <= is_vset ? vset_vl : (err ? '0 : old_val);
            rsp_err   <= err;
        end
    end

    no_second_accept: assert property (@(posedge clk) disable iff (rst)
        accept |=> rsp_valid && !accept
    ) else $error("request accepted while a response is pending");

    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)
    ) else $error("response changed while stalled");

endmodule

/* rtl/riscv_v_csr_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector CSR block top level
// Access unit, vsetvl logic and register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module riscv_v_csr_top #(
    parameter int unsigned VLEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  riscv_pkg::csr_op_t         req_op,
    input  logic [11:0]                req_addr,
    input  logic [riscv_pkg::XLEN-1:0] req_wdata,
    input  logic [riscv_pkg::XLEN-1:0] req_avl,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output logic [riscv_pkg::XLEN-1:0] rsp_rdata,
    output logic                       rsp_err,
    input  logic                       sat_set
);
    import riscv_v_pkg::*;

    riscv_v_vstart_t vstart_q;
    riscv_v_vxsat_t  vxsat_q;
    riscv_v_vxrm_t   vxrm_q;
    riscv_v_vl_t     vl_q;
    riscv_v_vtype_t  vtype_q;
    riscv_v_vlenb_t  vlenb_q;
    riscv_v_vcsr_t   vcsr_q;

    logic            vstart_wr_en;
    riscv_v_vstart_t vstart_wdata;
    logic            vxsat_wr_en;
    riscv_v_vxsat_t  vxsat_wdata;
    logic            vxrm_wr_en;
    riscv_v_vxrm_t   vxrm_wdata;
    logic            vl_wr_en;
    riscv_v_vl_t     vl_wdata;
    logic            vtype_wr_en;
    riscv_v_vtype_t  vtype_wdata;

    riscv_v_vl_t     vset_avl;
    riscv_v_vtype_t  vset_vtype;
    riscv_v_vl_t     vset_vl;
    riscv_v_vtype_t  vset_vtype_new;

    riscv_v_csr_access u_access (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_avl        (req_avl),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp_rdata      (rsp_rdata),
        .rsp_err        (rsp_err),
        .vstart_q       (vstart_q),
        .vxsat_q        (vxsat_q),
        .vxrm_q         (vxrm_q),
        .vl_q           (vl_q),
        .vtype_q        (vtype_q),
        .vlenb_q        (vlenb_q),
        .vcsr_q         (vcsr_q),
        .vstart_wr_en   (vstart_wr_en),
        .vstart_wdata   (vstart_wdata),
        .vxsat_wr_en    (vxsat_wr_en),
        .vxsat_wdata    (vxsat_wdata),
        .vxrm_wr_en     (vxrm_wr_en),
        .vxrm_wdata     (vxrm_wdata),
        .vl_wr_en       (vl_wr_en),
        .vl_wdata       (vl_wdata),
        .vtype_wr_en    (vtype_wr_en),
        .vtype_wdata    (vtype_wdata),
        .vset_avl       (vset_avl),
        .vset_vtype     (vset_vtype),
        .vset_vl        (vset_vl),
        .vset_vtype_new (vset_vtype_new)
    );

    riscv_v_vsetvl #(
        .VLEN (VLEN)
    ) u_vsetvl (
        .avl       (vset_avl),
        .vtype_req (vset_vtype),
        .new_vl    (vset_vl),
        .new_vtype (vset_vtype_new)
    );

    riscv_v_csr #(
        .VLEN (VLEN)
    ) u_csr (
        .clk          (clk),
        .rst          (rst),
        .sat_set      (sat_set),
        .vstart_wr_en (vstart_wr_en),
        .vstart_wdata (vstart_wdata),
        .vxsat_wr_en  (vxsat_wr_en),
        .vxsat_wdata  (vxsat_wdata),
        .vxrm_wr_en   (vxrm_wr_en),
        .vxrm_wdata   (vxrm_wdata),
        .vl_wr_en     (vl_wr_en),
        .vl_wdata     (vl_wdata),
        .vtype_wr_en  (vtype_wr_en),
        .vtype_wdata  (vtype_wdata),
        .vstart_q     (vstart_q),
        .vxsat_q      (vxsat_q),
        .vxrm_q       (vxrm_q),
        .vl_q         (vl_q),
        .vtype_q      (vtype_q),
        .vlenb_q      (vlenb_q),
        .vcsr_q       (vcsr_q)
    );

endmodule

/* rtl/riscv_v_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector extension register layouts
// Field types, reset values and SEW decode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package riscv_v_pkg;

    // vtype as laid out in the architectural register
    typedef struct packed {
        logic                        vill;
        logic [riscv_pkg::XLEN-10:0] reserved;
        logic                        vma;
        logic                        vta;
        logic [2:0]                  vsew;
        logic [2:0]                  vlmul;
    } riscv_v_vtype_t;

    typedef logic [riscv_pkg::XLEN-1:0] riscv_v_vl_t;
    typedef logic [riscv_pkg::XLEN-1:0] riscv_v_vstart_t;
    typedef logic [riscv_pkg::XLEN-1:0] riscv_v_vlenb_t;

    typedef struct packed {
        logic [1:0] rounding_mode;
    } riscv_v_vxrm_t;

    typedef struct packed {
        logic saturate;
    } riscv_v_vxsat_t;

    // vcsr view, vxrm above vxsat
    typedef struct packed {
        logic [1:0] rounding_mode;
        logic       saturate;
    } riscv_v_vcsr_t;

    localparam logic [2:0] LMUL_1 = 3'd0;

    localparam riscv_v_vtype_t RISCV_V_VTYPE_RST_VAL = '{
        vill: 1'b1, reserved: '0, vma: 1'b0, vta: 1'b0, vsew: 3'd0, vlmul: 3'd0
    };
    localparam riscv_v_vl_t     RISCV_V_VL_RST_VAL     = '0;
    localparam riscv_v_vstart_t RISCV_V_VSTART_RST_VAL = '0;
    localparam riscv_v_vxrm_t   RISCV_V_VXRM_RST_VAL   = '{rounding_mode: 2'd0};
    localparam riscv_v_vxsat_t  RISCV_V_VXSAT_RST_VAL  = '{saturate: 1'b0};

    // Element width in bits, 0 for reserved encodings
    function automatic logic [6:0] riscv_v_sew_bits(input logic [2:0] vsew);
        case (vsew)
            3'd0:    return 7'd8;
            3'd1:    return 7'd16;
            3'd2:    return 7'd32;
            3'd3:    return 7'd64;
            default: return 7'd0;
        endcase
    endfunction

endpackage

/* rtl/riscv_v_vsetvl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vsetvl evaluation
// Derives vlmax, the new vl and vill from an
// AVL and a requested vtype, combinationally
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module riscv_v_vsetvl #(
    parameter int unsigned VLEN = 128
) (
    input  riscv_v_pkg::riscv_v_vl_t    avl,
    input  riscv_v_pkg::riscv_v_vtype_t vtype_req,
    output riscv_v_pkg::riscv_v_vl_t    new_vl,
    output riscv_v_pkg::riscv_v_vtype_t new_vtype
);
    import riscv_v_pkg::*;

    logic [6:0]  sew;
    logic        legal;
    riscv_v_vl_t vlmax;

    assign sew = riscv_v_sew_bits(vtype_req.vsew);

    // Only LMUL=1, so vlmax is one register's worth of elements
    always_comb begin
        case (sew)
            7'd8:    vlmax = riscv_v_vl_t'(VLEN / 8);
            7'd16:   vlmax = riscv_v_vl_t'(VLEN / 16);
            7'd32:   vlmax = riscv_v_vl_t'(VLEN / 32);
            7'd64:   vlmax = riscv_v_vl_t'(VLEN / 64);
            default: vlmax = '0;
        endcase
    end

    assign legal = (sew != 7'd0)
                && (vtype_req.vlmul == LMUL_1)
                && (vtype_req.reserved == '0);

    always_comb begin
        if (legal) begin
            new_vtype.vill     = 1'b0;
            new_vtype.reserved = '0;
            new_vtype.vma      = vtype_req.vma;
            new_vtype.vta      = vtype_req.vta;
            new_vtype.vsew     = vtype_req.vsew;
            new_vtype.vlmul    = vtype_req.vlmul;
            new_vl             = (avl < vlmax) ? avl : vlmax;
        end else begin
            // Illegal setting leaves only vill
            new_vtype      = '0;
            new_vtype.vill = 1'b1;
            new_vl         = '0;
        end
    end

endmodule
